/* dv/ioDevModel.sv */
module ioDevModel import warpIoPkg::*; (
	input logic fclk,
	input logic c8mEn,
	input fsbAddrT aIob,
	input ioDataT dIobOut,
	output ioDataT dIobIn,
	input logic nAsIob,
	input logic nUdsIob,
	input logic nLdsIob,
	input logic nWeIob,
	output logic nDtackIob,
	output logic nBerrIob
);
	timeunit 1ns;
	timeprecision 100ps;

	// every write seen on the IOB, in the order the cycles ran.
	fsbAddrT logAddr [$];
	ioDataT logData [$];
	byteSelT logSel [$];

	integer seed = 32'h7034e23e; // fixed, so the device latencies repeat from run to run.
	int waitLeft; // c8mEn cycles still to go before the answer.

	// the model works on the falling edge of fclk.
	// the master samples on the rising edge, so nothing here races with it.
	initial begin
		dIobIn = '0;
		nDtackIob = 1'b1;
		nBerrIob = 1'b1;
		forever begin
			@(negedge fclk);
			if (!nAsIob) begin
				if (!nWeIob) begin
					logAddr.push_back(aIob);
					logData.push_back(dIobOut);
					logSel.push_back({!nUdsIob, !nLdsIob});
				end
				waitLeft = 1 + ($unsigned($random(seed)) % 3);
				// c8mEn high here means the next rising edge is an 8 MHz step.
				while (waitLeft > 0) begin
					if (c8mEn) waitLeft = waitLeft - 1;
					if (waitLeft > 0) @(negedge fclk);
				end
				dIobIn = aIob[16:1] ^ 16'h5a3c; // read data follows the address.
				if (aIob[1]) nBerrIob = 1'b0; // this part of the map always faults.
				else nDtackIob = 1'b0;
				// the answer is held until the master lets go of AS.
				while (!nAsIob) @(negedge fclk);
				nDtackIob = 1'b1;
				nBerrIob = 1'b1;
			end
		end
	end

endmodule

/* dv/warpIoTb.sv */
`include "warpIoCfg_cfg.svh"

module warpIoTb import warpIoPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	localparam int CLK_PERIOD = 4;
	localparam int BURST_LEN = `IO_FIFO_DEPTH + 3; // enough to fill the queue and stall.

	logic fclk, rstN, c8mEn;
	fsbAddrT aFsb;
	logic nAsFsb, nUdsFsb, nLdsFsb, nWeFsb;
	ioDataT dFsbOut, dFsbIn;
	logic nDtackFsb, nBerrFsb;
	fsbAddrT aIob;
	ioDataT dIobOut, dIobIn;
	logic nAsIob, nUdsIob, nLdsIob, nWeIob, nDtackIob, nBerrIob;

	logic [1:0] c8mCnt; // divides fclk down to the 8 MHz step.
	string testName;
	int testErrs, errTotal, testsPassed, testsFailed;
	int issuedWr; // writes sent into the I/O window so far.
	int nLogged; // device log entries already compared.

	// writes that should show up on the IOB, oldest first.
	fsbAddrT expWrAddr [$];
	ioDataT expWrData [$];
	byteSelT expWrSel [$];

	// FSB results waiting for the checker.
	string resWhat [$];
	logic [31:0] resExp [$];
	logic [31:0] resAct [$];

	logic [40:0] expW, actW;
	logic [31:0] expR, actR;
	string whatR;

	warpIo dut_i (.*);
	ioDevModel devI (.*);

	always #(CLK_PERIOD / 2.0) fclk = ~fclk;

	always @(posedge fclk) begin
		#0.5;
		c8mCnt = c8mCnt + 2'd1;
		c8mEn = (c8mCnt == 2'd0); // high for one fclk cycle in four.
	end

	// expected read result. bit 16 flags a bus error, the rest is the data.
	function automatic logic [16:0] expectRead(input fsbAddrT addr);
		if (addr[23:22] == `UNMAP_CODE) return {1'b1, 16'h0000}; // never reaches the IOB.
		if (addr[1]) return {1'b1, 16'h0000}; // the device faults on these.
		return {1'b0, addr[16:1] ^ 16'h5a3c};
	endfunction

	function automatic logic isPosted(input fsbAddrT addr);
		return (addr[23:22] == `IO_WIN_CODE) && addr[`PW_BIT];
	endfunction

	function automatic fsbAddrT ioAddr(input logic pw, input logic [19:0] offset);
		return {`IO_WIN_CODE, pw, offset};
	endfunction

	task automatic queueCheck(input string what, input logic [31:0] exp, input logic [31:0] act);
		resWhat.push_back(what);
		resExp.push_back(exp);
		resAct.push_back(act);
	endtask

	// one FSB cycle. result is {berr, dtack, data} as seen at the termination.
	task automatic runCycle(input fsbAddrT addr, input logic we, input ioDataT data,
			input byteSelT sel, output logic [17:0] result);
		@(posedge fclk);
		#0.5;
		aFsb = addr;
		dFsbOut = data;
		nWeFsb = !we;
		nUdsFsb = !sel[1];
		nLdsFsb = !sel[0];
		nAsFsb = 1'b0;
		do begin
			@(posedge fclk);
			#0.5;
		end while (nDtackFsb && nBerrFsb);
		result = {!nBerrFsb, !nDtackFsb, dFsbIn};
		nAsFsb = 1'b1; // the bridge drops its termination on the next edge.
		nUdsFsb = 1'b1;
		nLdsFsb = 1'b1;
		nWeFsb = 1'b1;
	endtask

	task automatic fsbWrite(input fsbAddrT addr, input ioDataT data, input byteSelT sel);
		logic [17:0] res;
		logic [16:0] expRd;
		logic berr;
		expRd = expectRead(addr);
		berr = expRd[16] && !isPosted(addr); // a posted write is released before any fault.
		if (addr[23:22] == `IO_WIN_CODE) begin
			expWrAddr.push_back(addr);
			expWrData.push_back(data);
			expWrSel.push_back(sel);
			issuedWr++;
		end
		runCycle(addr, 1'b1, data, sel, res);
		queueCheck("write termination", {14'b0, berr, !berr, 16'h0}, {14'b0, res[17:16], 16'h0});
		if ((addr[23:22] == `IO_WIN_CODE) && !isPosted(addr))
			queueCheck("writes logged before DTACK", issuedWr, devI.logAddr.size());
	endtask

	task automatic fsbRead(input fsbAddrT addr);
		logic [17:0] res;
		logic [16:0] expRd;
		expRd = expectRead(addr);
		runCycle(addr, 1'b0, 16'h0000, 2'b11, res);
		// a bus error carries no data.
		queueCheck("read result",
			{14'b0, expRd[16], !expRd[16], expRd[16] ? 16'h0 : expRd[15:0]},
			{14'b0, res[17:16], expRd[16] ? 16'h0 : res[15:0]});
		if (addr[23:22] == `IO_WIN_CODE)
			queueCheck("writes logged before the read", issuedWr, devI.logAddr.size());
	endtask

	task automatic finishTest();
		// posted writes may still be draining on the IOB.
		while ((expWrAddr.size() != 0) || (resExp.size() != 0)) begin
			@(posedge fclk);
			#0.5;
		end
		if (testErrs == 0) begin
			$display("test %s: passed", testName);
			testsPassed++;
		end else begin
			$display("test %s: failed with %0d errors", testName, testErrs);
			testsFailed++;
		end
		errTotal += testErrs;
		testErrs = 0;
	endtask

	always @(posedge fclk) begin
		// each write the device logged must be the oldest one still expected.
		while (devI.logAddr.size() > nLogged) begin
			actW = {devI.logAddr[nLogged], devI.logData[nLogged], devI.logSel[nLogged]};
			if (expWrAddr.size() == 0) begin
				$display("%s: the device logged a write that was never issued (%h)", testName, actW);
				testErrs++;
			end else begin
				expW = {expWrAddr.pop_front(), expWrData.pop_front(), expWrSel.pop_front()};
				if (actW !== expW) begin
					$display("ERROR %s: IOB write expected %h actual %h", testName, expW, actW);
					testErrs++;
				end
			end
			nLogged++;
		end
		while (resExp.size() > 0) begin
			expR = resExp.pop_front();
			actR = resAct.pop_front();
			whatR = resWhat.pop_front();
			if (actR !== expR) begin
				$display("ERROR %s: %s expected %h actual %h", testName, whatR, expR, actR);
				testErrs++;
			end
		end
	end

	initial begin
		#((NUM_TESTS * 200 + 10) * CLK_PERIOD);
		$display("timeout: a bus cycle never terminated during test %s", testName);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		fclk = 1'b0;
		rstN = 1'b0;
		c8mEn = 1'b0;
		c8mCnt = 2'd0;
		aFsb = '0;
		nAsFsb = 1'b1;
		nUdsFsb = 1'b1;
		nLdsFsb = 1'b1;
		nWeFsb = 1'b1;
		dFsbOut = '0;
		testErrs = 0;
		errTotal = 0;
		testsPassed = 0;
		testsFailed = 0;
		issuedWr = 0;
		nLogged = 0;
		testName = "reset";
		repeat (10) @(posedge fclk);
		#0.5;
		rstN = 1'b1;

		testName = "posted writes";
		fsbWrite(ioAddr(1'b1, 20'h00100), 16'hbeef, 2'b11);
		fsbWrite(ioAddr(1'b1, 20'h00202), 16'h12ab, 2'b10);
		fsbWrite(ioAddr(1'b1, 20'h00304), 16'h00c5, 2'b01);
		finishTest();

		testName = "read and non-posted write";
		fsbRead(ioAddr(1'b0, 20'h01234));
		fsbWrite(ioAddr(1'b0, 20'h00a40), 16'h7e57, 2'b11);
		finishTest();

		testName = "unmapped access";
		fsbWrite({`UNMAP_CODE, 21'h000400}, 16'hdead, 2'b11);
		fsbRead({`UNMAP_CODE, 21'h1f0010});
		finishTest();

		testName = "IOB bus error";
		fsbRead(ioAddr(1'b0, 20'h00811)); // address bit 1 set.
		finishTest();

		testName = "back-pressure burst";
		for (int i = 0; i < BURST_LEN; i++)
			fsbWrite(ioAddr(1'b1, 20'h02000 + 20'(i * 2)), 16'h1000 + 16'(i * 16'h0111), 2'b11);
		finishTest();

		testName = "read after writes";
		for (int i = 0; i < `IO_FIFO_DEPTH; i++)
			fsbWrite(ioAddr(1'b1, 20'h03000 + 20'(i * 4)), 16'hc000 | 16'(i), 2'b11);
		fsbRead(ioAddr(1'b0, 20'h03ffe));
		finishTest();

		$display("tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed, errTotal);
		if ((errTotal == 0) && (testsFailed == 0)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/warpIoPkg.sv
src/ioReqIf.sv
src/addrDecode.sv
src/ioBusSlave.sv
src/ioReqFifo.sv
src/ioBusMaster.sv
src/warpIo.sv
dv/ioDevModel.sv
dv/warpIoTb.sv

/* src/addrDecode.sv */
`include "warpIoCfg_cfg.svh"

module addrDecode import warpIoPkg::*; (
	input fsbAddrT addr,
	output logic ioCs,
	output logic ioPwCs,
	output logic unmapCs
);

	// the whole address map of the bridge is kept here.
	// ranges 00 and 01 belong to RAM and ROM, so no select fires for them and the
	// slave leaves such cycles alone.
	logic [1:0] region; // top two address bits pick the region.

	assign region = addr[23:22];

	always_comb begin
		ioCs = 1'b0;
		unmapCs = 1'b0;
		case (region)
			`IO_WIN_CODE: ioCs = 1'b1; // peripheral space on the IOB.
			`UNMAP_CODE: unmapCs = 1'b1; // ends in BERR without an IOB cycle.
			default: begin
				ioCs = 1'b0;
				unmapCs = 1'b0;
			end
		endcase
	end

	// the posted half of the I/O window.
	// the read or write qualification is left to the slave, which sees nWeFsb.
	assign ioPwCs = ioCs && addr[`PW_BIT];

endmodule

/* src/ioBusMaster.sv */
module ioBusMaster import warpIoPkg::*; (
	input logic fclk,
	input logic rstN,
	input logic c8mEn,
	ioReqIf.consumer reqOut,
	output fsbAddrT aIob,
	output ioDataT dIobOut,
	input ioDataT dIobIn,
	output logic nAsIob,
	output logic nUdsIob,
	output logic nLdsIob,
	output logic nWeIob,
	input logic nDtackIob,
	input logic nBerrIob,
	output logic ioDone,
	output logic ioBerr,
	output ioDataT ioRdData
);

	masterStateT state;

	// control fields of the request in progress.
	logic weR;
	byteSelT selR;
	logic postedR;

	logic pop; // take the head of the FIFO on this edge.
	logic ackSeen; // the device acknowledged or faulted on this c8mEn.

	// a request leaves the FIFO only on an 8 MHz step while the master is free.
	assign pop = c8mEn && (state == mIdle) && reqOut.valid;
	assign reqOut.ready = pop;

	assign ackSeen = c8mEn && (state == mWaitAck) && (!nDtackIob || !nBerrIob);

	// address and data-out registers. they do the job of the board's latches
	// and hold their value for the whole IOB cycle.
	always_ff @(posedge fclk) begin
		if (pop) begin
			aIob <= reqOut.addr;
			dIobOut <= reqOut.data;
			weR <= reqOut.we;
			selR <= reqOut.sel;
			postedR <= reqOut.posted;
		end
		if (ackSeen) begin
			ioRdData <= dIobIn; // sampled along with the acknowledge.
		end
	end

	always_ff @(posedge fclk) begin
		if (!rstN) begin
			state <= mIdle;
			nAsIob <= 1'b1;
			nUdsIob <= 1'b1;
			nLdsIob <= 1'b1;
			nWeIob <= 1'b1;
			ioDone <= 1'b0;
			ioBerr <= 1'b0;
		end else begin
			ioDone <= 1'b0; // a single-cycle pulse.
			if (c8mEn) begin
				case (state)
					mIdle: begin
						if (reqOut.valid) state <= mAssertAs;
					end
					mAssertAs: begin
						// address, direction and strobes go out together.
						nAsIob <= 1'b0;
						nUdsIob <= !selR[1];
						nLdsIob <= !selR[0];
						nWeIob <= !weR;
						state <= mWaitAck;
					end
					mWaitAck: begin
						// the device decides how long this lasts.
						if (!nBerrIob) begin
							ioBerr <= 1'b1; // a bus error wins over a late DTACK.
							state <= mRelease;
						end else if (!nDtackIob) begin
							ioBerr <= 1'b0;
							state <= mRelease;
						end
					end
					mRelease: begin
						nAsIob <= 1'b1;
						nUdsIob <= 1'b1;
						nLdsIob <= 1'b1;
						nWeIob <= 1'b1;
						// posted writes were acknowledged long ago, so an error on one is dropped.
						ioDone <= !postedR;
						state <= mIdle;
					end
					default: state <= mIdle;
				endcase
			end
		end
	end

endmodule

/* src/ioBusSlave.sv */
module ioBusSlave import warpIoPkg::*; (
	input logic fclk,
	input logic rstN,
	input logic nAsFsb,
	input logic nUdsFsb,
	input logic nLdsFsb,
	input logic nWeFsb,
	input fsbAddrT addr,
	input ioDataT wrData,
	input logic ioCs,
	input logic ioPwCs,
	input logic unmapCs,
	ioReqIf.producer reqIn,
	input logic ioDone,
	input logic ioBerr,
	input ioDataT ioRdData,
	output ioDataT rdData,
	output logic nDtackFsb,
	output logic nBerrFsb
);

	slaveStateT state;

	// request word held from the start of the cycle until it is pushed.
	fsbAddrT addrR;
	ioDataT dataR;
	logic weR;
	byteSelT selR;
	logic postedR;

	logic startIo; // an FSB cycle into the I/O window begins this cycle.
	logic startUnmap; // an FSB cycle into the unmapped region begins this cycle.
	logic push; // the FIFO takes the request word on this edge.

	// a cycle is recognised on the first edge that sees AS low with a select.
	assign startIo = (state == sIdle) && !nAsFsb && ioCs;
	assign startUnmap = (state == sIdle) && !nAsFsb && unmapCs;

	// valid is only raised while the FIFO has room, so it is a one-cycle push strobe.
	assign reqIn.valid = (state == sQueue) && reqIn.ready;
	assign push = reqIn.valid && reqIn.ready;

	assign reqIn.addr = addrR;
	assign reqIn.data = dataR; // data travels from the capture register.
	assign reqIn.we = weR;
	assign reqIn.sel = selR;
	assign reqIn.posted = postedR;

	// capture the request and the read data.
	// the strobes and nWeFsb are driven together with AS on this bus, so they are
	// already valid on the start edge.
	always_ff @(posedge fclk) begin
		if (startIo) begin
			addrR <= addr;
			dataR <= wrData;
			weR <= !nWeFsb;
			selR <= {!nUdsFsb, !nLdsFsb};
			postedR <= !nWeFsb && ioPwCs; // only writes into the posted half are posted.
		end
		if ((state == sWaitDone) && ioDone && !weR) begin
			rdData <= ioRdData; // held on dFsbIn until the next read completes.
		end
	end

	always_ff @(posedge fclk) begin
		if (!rstN) begin
			state <= sIdle;
			nDtackFsb <= 1'b1;
			nBerrFsb <= 1'b1;
		end else begin
			case (state)
				sIdle: begin
					if (startUnmap) begin
						nBerrFsb <= 1'b0; // nothing is queued for an unmapped access.
						state <= sTerm;
					end else if (startIo) begin
						state <= sQueue;
					end
				end
				sQueue: begin
					// stays here as long as the FIFO is full.
					if (push) begin
						if (postedR) begin
							nDtackFsb <= 1'b0; // the CPU moves on right away.
							state <= sTerm;
						end else begin
							state <= sWaitDone;
						end
					end
				end
				sWaitDone: begin
					if (ioDone) begin
						nDtackFsb <= ioBerr; // an IOB bus error is passed back as BERR.
						nBerrFsb <= !ioBerr;
						state <= sTerm;
					end
				end
				sTerm: begin
					// the termination holds until the CPU lets go of AS.
					if (nAsFsb) begin
						nDtackFsb <= 1'b1;
						nBerrFsb <= 1'b1;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

/* src/ioReqFifo.sv */
`include "warpIoCfg_cfg.svh"

module ioReqFifo import warpIoPkg::*; (
	input logic fclk,
	input logic rstN,
	ioReqIf.consumer reqIn,
	ioReqIf.producer reqOut
);

	localparam int DEPTH = `IO_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// one entry per field of the request word.
	fsbAddrT addrMem [DEPTH];
	ioDataT dataMem [DEPTH];
	logic weMem [DEPTH];
	byteSelT selMem [DEPTH];
	logic postedMem [DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count; // number of words held.

	logic push;
	logic pop;

	// pointers wrap by compare, so the depth need not be a power of two.
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign reqIn.ready = (count != CNT_W'(DEPTH)); // room for one more word.
	assign reqOut.valid = (count != '0); // the head entry is a real request.

	assign push = reqIn.valid && reqIn.ready;
	assign pop = reqOut.valid && reqOut.ready;

	// the head entry is presented combinationally to the master.
	assign reqOut.addr = addrMem[rdPtr];
	assign reqOut.data = dataMem[rdPtr];
	assign reqOut.we = weMem[rdPtr];
	assign reqOut.sel = selMem[rdPtr];
	assign reqOut.posted = postedMem[rdPtr];

	always_ff @(posedge fclk) begin
		if (push) begin
			addrMem[wrPtr] <= reqIn.addr;
			dataMem[wrPtr] <= reqIn.data;
			weMem[wrPtr] <= reqIn.we;
			selMem[wrPtr] <= reqIn.sel;
			postedMem[wrPtr] <= reqIn.posted;
		end
	end

	always_ff @(posedge fclk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			// a push and a pop together leave the count as it is.
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

endmodule

/* src/ioReqIf.sv */
interface ioReqIf import warpIoPkg::*; ();

	logic valid; // the request word below is offered this cycle.
	logic ready; // the receiving side takes it when this is high too.
	fsbAddrT addr; // word address of the access.
	ioDataT data; // write data, don't care on reads.
	logic we; // high for a write.
	byteSelT sel; // active-high byte lanes.
	logic posted; // the FSB cycle has already been acknowledged.

	// the side that offers request words.
	modport producer (
		output valid, addr, data, we, sel, posted,
		input ready
	);

	// the side that takes request words.
	modport consumer (
		input valid, addr, data, we, sel, posted,
		output ready
	);

endinterface

/* src/warpIo.sv */
module warpIo import warpIoPkg::*; (
	input logic fclk,
	input logic rstN,
	input logic c8mEn,
	input fsbAddrT aFsb,
	input logic nAsFsb,
	input logic nUdsFsb,
	input logic nLdsFsb,
	input logic nWeFsb,
	input ioDataT dFsbOut,
	output ioDataT dFsbIn,
	output logic nDtackFsb,
	output logic nBerrFsb,
	output fsbAddrT aIob,
	output ioDataT dIobOut,
	input ioDataT dIobIn,
	output logic nAsIob,
	output logic nUdsIob,
	output logic nLdsIob,
	output logic nWeIob,
	input logic nDtackIob,
	input logic nBerrIob
);

	logic ioCs, ioPwCs, unmapCs; // selects from the address map.
	logic ioDone, ioBerr; // completion of a non-posted IOB cycle.
	ioDataT ioRdData; // read data that goes with ioDone.

	ioReqIf reqIn (); // slave into the FIFO.
	ioReqIf reqOut (); // FIFO out to the master.

	addrDecode decodeI (
		.addr(aFsb), .ioCs(ioCs), .ioPwCs(ioPwCs), .unmapCs(unmapCs)
	);

	ioBusSlave slaveI (
		.fclk(fclk), .rstN(rstN),
		.nAsFsb(nAsFsb), .nUdsFsb(nUdsFsb), .nLdsFsb(nLdsFsb), .nWeFsb(nWeFsb),
		.addr(aFsb), .wrData(dFsbOut),
		.ioCs(ioCs), .ioPwCs(ioPwCs), .unmapCs(unmapCs),
		.reqIn(reqIn.producer),
		.ioDone(ioDone), .ioBerr(ioBerr), .ioRdData(ioRdData),
		.rdData(dFsbIn), .nDtackFsb(nDtackFsb), .nBerrFsb(nBerrFsb)
	);

	ioReqFifo fifoI (
		.fclk(fclk), .rstN(rstN), .reqIn(reqIn.consumer), .reqOut(reqOut.producer)
	);

	ioBusMaster masterI (
		.fclk(fclk), .rstN(rstN), .c8mEn(c8mEn),
		.reqOut(reqOut.consumer),
		.aIob(aIob), .dIobOut(dIobOut), .dIobIn(dIobIn),
		.nAsIob(nAsIob), .nUdsIob(nUdsIob), .nLdsIob(nLdsIob), .nWeIob(nWeIob),
		.nDtackIob(nDtackIob), .nBerrIob(nBerrIob),
		.ioDone(ioDone), .ioBerr(ioBerr), .ioRdData(ioRdData)
	);

endmodule

/* src/warpIoCfg_cfg.svh */
`ifndef WARPIOCFG_CFG_SVH
`define WARPIOCFG_CFG_SVH

// number of request words the queue between the FSB slave and the IOB master can hold.
`define IO_FIFO_DEPTH 4

// values of A[23:22] that select the two decoded regions.
`define IO_WIN_CODE 2'b11 // the I/O window of the host machine.
`define UNMAP_CODE 2'b10 // nothing lives here, so an access ends in a bus error.

// address bit that splits the I/O window into non-posted and posted halves.
// a write with this bit set is released on the FSB as soon as it is queued.
`define PW_BIT 21

`endif

/* src/warpIoPkg.sv */
package warpIoPkg;

	// word address of the FSB, byte lane picked by the data strobes.
	typedef logic [23:1] fsbAddrT;

	// one 16-bit word on either bus.
	typedef logic [15:0] ioDataT;

	// byte enables in active-high form. bit 1 is the upper lane, bit 0 the lower lane.
	typedef logic [1:0] byteSelT;

	// states of the FSB-side slave.
	// sQueue waits for room in the FIFO, sWaitDone waits for the IOB master.
	typedef enum logic [1:0] {
		sIdle,
		sQueue,
		sWaitDone,
		sTerm
	} slaveStateT;

	// states of the IOB master.
	// every transition is taken on a c8mEn cycle.
	typedef enum logic [1:0] {
		mIdle,
		mAssertAs,
		mWaitAck,
		mRelease
	} masterStateT;

endpackage
